/* hdl/radio_pkg.sv */
// Types, settings addresses and readback addresses for one radio slot.
// Imported by every module of the slot.
package radio_pkg;

   localparam int SAMPLE_W = 32;                  // converter word
   localparam int IQ_W     = SAMPLE_W / 2;        // one I or Q half

   localparam logic signed [IQ_W-1:0] IQ_MIN = {1'b1, {(IQ_W-1){1'b0}}};
   localparam logic signed [IQ_W-1:0] IQ_MAX = {1'b0, {(IQ_W-1){1'b1}}};

   typedef struct packed {
      logic signed [IQ_W-1:0] i;                  // upper half
      logic signed [IQ_W-1:0] q;                  // lower half
   } iq_t;

   // converter port sees raw, corrector sees iq
   typedef union packed {
      logic [SAMPLE_W-1:0] raw;
      iq_t                 iq;
   } sample_t;

   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   typedef struct packed {
      logic swap_iq;                              // data bit 2
      logic invert_i;                             // data bit 1
      logic invert_q;                             // data bit 0
   } fe_ctrl_t;

   typedef struct packed {
      logic [31:0] idle;
      logic [31:0] rx;
      logic [31:0] tx;
      logic [31:0] fdx;
      logic [31:0] ddr;                           // 1 = output
   } atr_cfg_t;

   // --------------------------------------------------
   // settings bus map
   // --------------------------------------------------
   localparam logic [7:0] SR_DB_BASE        = 8'd160;
   localparam logic [7:0] SR_GPIO_IDLE      = SR_DB_BASE + 8'd0;
   localparam logic [7:0] SR_GPIO_RX        = SR_DB_BASE + 8'd1;
   localparam logic [7:0] SR_GPIO_TX        = SR_DB_BASE + 8'd2;
   localparam logic [7:0] SR_GPIO_FDX       = SR_DB_BASE + 8'd3;
   localparam logic [7:0] SR_GPIO_DDR       = SR_DB_BASE + 8'd4;
   localparam logic [7:0] SR_MISC_OUT       = SR_DB_BASE + 8'd5;
   localparam logic [7:0] SR_TX_FE_BASE     = 8'd208;
   localparam logic [7:0] SR_RX_FE_BASE     = 8'd224;
   localparam logic [7:0] SR_FE_CHAN_OFFSET = 8'd16;   // stride between channels

   // --------------------------------------------------
   // readback map
   // --------------------------------------------------
   localparam logic [7:0] RB_DB_BASE  = 8'd16;
   localparam logic [7:0] RB_GPIO_IN  = RB_DB_BASE + 8'd0;
   localparam logic [7:0] RB_MISC_IN  = RB_DB_BASE + 8'd1;
   localparam logic [7:0] RB_MISC_OUT = RB_DB_BASE + 8'd2;

endpackage

/* hdl/radio_settings_ctrl.sv */
// Settings bus decoder for the slot. Holds every configuration register
// and answers readback requests one cycle after the request strobe.
module radio_settings_ctrl
   import radio_pkg::*;
#(
   parameter int NUM_RX_CHANNELS = 2,
   parameter int NUM_TX_CHANNELS = 1
)(
   input  logic                              radio_clk,
   input  logic                              i_reset,
   input  set_bus_t                          i_set,
   input  logic                              i_rb_stb,
   input  logic [7:0]                        i_rb_addr,
   input  logic [31:0]                       i_gpio_sampled,
   input  logic [31:0]                       i_misc_sampled,
   output atr_cfg_t                          o_atr_cfg,
   output fe_ctrl_t [NUM_RX_CHANNELS-1:0]    o_rx_fe,
   output fe_ctrl_t [NUM_TX_CHANNELS-1:0]    o_tx_fe,
   output logic [31:0]                       o_misc_word,
   output logic                              o_rb_valid,
   output logic [31:0]                       o_rb_data
);

   // address of one channel's front-end register
   function automatic logic [7:0] fe_addr(input logic [7:0] base, input int chan);
      logic [7:0] offset;
      offset = 8'(chan) * SR_FE_CHAN_OFFSET;
      return base + offset;
   endfunction

   // --------------------------------------------------
   // configuration registers
   // --------------------------------------------------
   always_ff @(posedge radio_clk)
   begin
      if (i_reset)
      begin
         o_atr_cfg   <= '0;                       // all gpio as inputs
         o_rx_fe     <= '0;
         o_tx_fe     <= '0;
         o_misc_word <= '0;
      end
      else if (i_set.stb)
      begin
         case (i_set.addr)
            SR_GPIO_IDLE: o_atr_cfg.idle <= i_set.data;
            SR_GPIO_RX:   o_atr_cfg.rx   <= i_set.data;
            SR_GPIO_TX:   o_atr_cfg.tx   <= i_set.data;
            SR_GPIO_FDX:  o_atr_cfg.fdx  <= i_set.data;
            SR_GPIO_DDR:  o_atr_cfg.ddr  <= i_set.data;
            SR_MISC_OUT:  o_misc_word    <= i_set.data;
            default:      ;                       // front-end regs below
         endcase

         for (int n = 0; n < NUM_RX_CHANNELS; n++)
         begin
            if (i_set.addr == fe_addr(SR_RX_FE_BASE, n))
               o_rx_fe[n] <= fe_ctrl_t'(i_set.data[2:0]);
         end

         for (int n = 0; n < NUM_TX_CHANNELS; n++)
         begin
            if (i_set.addr == fe_addr(SR_TX_FE_BASE, n))
               o_tx_fe[n] <= fe_ctrl_t'(i_set.data[2:0]);
         end
      end
   end

   // --------------------------------------------------
   // readback
   // --------------------------------------------------
   always_ff @(posedge radio_clk)
   begin
      if (i_reset)
         o_rb_valid <= 1'b0;
      else
         o_rb_valid <= i_rb_stb;                  // one cycle after the request
   end

   always_ff @(posedge radio_clk)
   begin
      if (i_rb_stb)
      begin
         case (i_rb_addr)
            RB_GPIO_IN:  o_rb_data <= i_gpio_sampled;
            RB_MISC_IN:  o_rb_data <= i_misc_sampled;
            RB_MISC_OUT: o_rb_data <= o_misc_word;
            default:     o_rb_data <= '0;         // unmapped reads zero
         endcase
      end
   end

endmodule

/* hdl/atr_gpio.sv */
// Daughterboard GPIO driven by transmit/receive run state, plus the LEDs.
// Also samples the GPIO inputs for readback.
module atr_gpio
   import radio_pkg::*;
(
   input  logic        radio_clk,
   input  logic        i_reset,
   input  atr_cfg_t    i_cfg,
   input  logic        i_run_rx,
   input  logic        i_run_tx,
   input  logic [31:0] i_gpio_in,
   output logic [31:0] o_gpio_out,
   output logic [31:0] o_gpio_ddr,
   output logic [2:0]  o_led,
   output logic [31:0] o_gpio_sampled
);

   logic [31:0] atr_word;

   // pick the output word for the current run state
   always_comb
   begin
      case ({i_run_tx, i_run_rx})
         2'b00:   atr_word = i_cfg.idle;
         2'b01:   atr_word = i_cfg.rx;
         2'b10:   atr_word = i_cfg.tx;
         default: atr_word = i_cfg.fdx;           // full duplex
      endcase
   end

   // --------------------------------------------------
   // output registers
   // --------------------------------------------------
   always_ff @(posedge radio_clk)
   begin
      if (i_reset)
      begin
         o_gpio_out <= '0;
         o_gpio_ddr <= '0;
         o_led      <= '0;
      end
      else
      begin
         o_gpio_out <= atr_word;
         o_gpio_ddr <= i_cfg.ddr;
         // {rx antenna, txrx tx, txrx rx}
         o_led      <= {i_run_rx & ~i_run_tx, i_run_tx, i_run_rx};
      end
   end

   always_ff @(posedge radio_clk)
   begin
      o_gpio_sampled <= i_gpio_in;                // single sample stage
   end

endmodule

/* hdl/fe_iq_corrector.sv */
// Front-end correction per channel: optional I/Q swap, then optional
// saturating negation of each half. One register stage, one sample per cycle.
module fe_iq_corrector
   import radio_pkg::*;
#(
   parameter int NUM_CHANNELS = 1
)(
   input  logic                           radio_clk,
   input  logic                           i_reset,
   input  fe_ctrl_t [NUM_CHANNELS-1:0]    i_ctrl,
   input  logic [NUM_CHANNELS-1:0]        i_stb,
   input  sample_t [NUM_CHANNELS-1:0]     i_data,
   output logic [NUM_CHANNELS-1:0]        o_stb,
   output sample_t [NUM_CHANNELS-1:0]     o_data
);

   // -full scale has no positive twin so it clips
   function automatic logic signed [IQ_W-1:0] sat_negate(input logic signed [IQ_W-1:0] x);
      if (x == IQ_MIN)
         return IQ_MAX;
      else
         return -x;
   endfunction

   iq_t [NUM_CHANNELS-1:0] swapped;
   iq_t [NUM_CHANNELS-1:0] corrected;

   for (genvar n = 0; n < NUM_CHANNELS; n++)
   begin : g_chan
      assign swapped[n] = i_ctrl[n].swap_iq ? {i_data[n].iq.q, i_data[n].iq.i}
                                            : i_data[n].iq;
      assign corrected[n].i = i_ctrl[n].invert_i ? sat_negate(swapped[n].i)
                                                 : swapped[n].i;
      assign corrected[n].q = i_ctrl[n].invert_q ? sat_negate(swapped[n].q)
                                                 : swapped[n].q;
   end

   // --------------------------------------------------
   // pipeline register
   // --------------------------------------------------
   always_ff @(posedge radio_clk)
   begin
      if (i_reset)
         o_stb <= '0;
      else
         o_stb <= i_stb;
   end

   always_ff @(posedge radio_clk)
   begin
      for (int n = 0; n < NUM_CHANNELS; n++)
      begin
         o_data[n].iq <= corrected[n];            // valid while o_stb is high
      end
   end

endmodule

/* hdl/radio_frontend_top.sv */
// One radio slot: settings decode, ATR GPIO and front-end correction.
// Channel counts are set here and passed down.
module radio_frontend_top
   import radio_pkg::*;
#(
   parameter int NUM_RX_CHANNELS = 2,
   parameter int NUM_TX_CHANNELS = 1
)(
   input  logic                              radio_clk,
   input  logic                              i_reset,
   input  set_bus_t                          i_set,
   input  logic                              i_rb_stb,
   input  logic [7:0]                        i_rb_addr,
   input  logic                              i_run_rx,
   input  logic                              i_run_tx,
   input  logic                              i_rx_stb,
   input  sample_t                           i_rx_data,
   input  logic                              i_tx_stb,
   input  sample_t [NUM_TX_CHANNELS-1:0]     i_tx_data,
   input  logic [31:0]                       i_db_gpio_in,
   input  logic [31:0]                       i_misc_in,
   output logic                              o_rb_valid,
   output logic [31:0]                       o_rb_data,
   output logic [NUM_RX_CHANNELS-1:0]        o_rx_stb,
   output sample_t [NUM_RX_CHANNELS-1:0]     o_rx_data,
   output logic [NUM_TX_CHANNELS-1:0]        o_tx_stb,
   output sample_t [NUM_TX_CHANNELS-1:0]     o_tx_data,
   output logic [31:0]                       o_db_gpio_out,
   output logic [31:0]                       o_db_gpio_ddr,
   output logic [2:0]                        o_radio_led,
   output logic [31:0]                       o_misc_out
);

   atr_cfg_t                       atr_cfg;
   fe_ctrl_t [NUM_RX_CHANNELS-1:0] rx_fe;
   fe_ctrl_t [NUM_TX_CHANNELS-1:0] tx_fe;
   logic [31:0]                    misc_word;
   logic [31:0]                    gpio_sampled;
   logic [31:0]                    misc_in_r;

   radio_settings_ctrl #(
      .NUM_RX_CHANNELS(NUM_RX_CHANNELS),
      .NUM_TX_CHANNELS(NUM_TX_CHANNELS)
   ) radio_settings_ctrl_inst (
      .radio_clk      (radio_clk),
      .i_reset        (i_reset),
      .i_set          (i_set),
      .i_rb_stb       (i_rb_stb),
      .i_rb_addr      (i_rb_addr),
      .i_gpio_sampled (gpio_sampled),
      .i_misc_sampled (misc_in_r),
      .o_atr_cfg      (atr_cfg),
      .o_rx_fe        (rx_fe),
      .o_tx_fe        (tx_fe),
      .o_misc_word    (misc_word),
      .o_rb_valid     (o_rb_valid),
      .o_rb_data      (o_rb_data)
   );

   atr_gpio atr_gpio_inst (
      .radio_clk      (radio_clk),
      .i_reset        (i_reset),
      .i_cfg          (atr_cfg),
      .i_run_rx       (i_run_rx),
      .i_run_tx       (i_run_tx),
      .i_gpio_in      (i_db_gpio_in),
      .o_gpio_out     (o_db_gpio_out),
      .o_gpio_ddr     (o_db_gpio_ddr),
      .o_led          (o_radio_led),
      .o_gpio_sampled (gpio_sampled)
   );

   // --------------------------------------------------
   // front-end correction
   // --------------------------------------------------
   fe_iq_corrector #(
      .NUM_CHANNELS(NUM_RX_CHANNELS)
   ) rx_corrector_inst (
      .radio_clk (radio_clk),
      .i_reset   (i_reset),
      .i_ctrl    (rx_fe),
      .i_stb     ({NUM_RX_CHANNELS{i_rx_stb}}),
      .i_data    ({NUM_RX_CHANNELS{i_rx_data.raw}}),   // same adc word on every channel
      .o_stb     (o_rx_stb),
      .o_data    (o_rx_data)
   );

   fe_iq_corrector #(
      .NUM_CHANNELS(NUM_TX_CHANNELS)
   ) tx_corrector_inst (
      .radio_clk (radio_clk),
      .i_reset   (i_reset),
      .i_ctrl    (tx_fe),
      .i_stb     ({NUM_TX_CHANNELS{i_tx_stb}}),
      .i_data    (i_tx_data),
      .o_stb     (o_tx_stb),
      .o_data    (o_tx_data)
   );

   // --------------------------------------------------
   // misc i/o registers
   // --------------------------------------------------
   always_ff @(posedge radio_clk)
   begin
      if (i_reset)
         o_misc_out <= '0;
      else
         o_misc_out <= misc_word;                 // second stage after the write
   end

   always_ff @(posedge radio_clk)
   begin
      misc_in_r <= i_misc_in;
   end

endmodule

/* verification/radio_frontend_assertions.sv */
// Protocol assertions for one radio slot, bound into the top level below.
module radio_frontend_assertions #(
   parameter int NUM_RX_CHANNELS = 2,
   parameter int NUM_TX_CHANNELS = 1
)(
   input logic                       radio_clk,
   input logic                       i_reset,
   input logic                       i_rb_stb,
   input logic                       i_rx_stb,
   input logic                       o_rb_valid,
   input logic [NUM_RX_CHANNELS-1:0] o_rx_stb,
   input logic [NUM_TX_CHANNELS-1:0] o_tx_stb
);
   timeunit 1ns;
   timeprecision 1ns;

   rb_latency: assert property (@(posedge radio_clk) disable iff (i_reset)
      o_rb_valid == $past(i_rb_stb))
      else $error("readback valid does not match the request one cycle earlier");

   for (genvar n = 0; n < NUM_RX_CHANNELS; n++)
   begin : g_rx
      rx_latency: assert property (@(posedge radio_clk) disable iff (i_reset)
         o_rx_stb[n] == $past(i_rx_stb))
         else $error("rx output strobe %0d does not follow the input strobe", n);
   end

   // strobes cleared by the reset edge
   reset_quiet: assert property (@(posedge radio_clk)
      $past(i_reset) |-> (!o_rb_valid && o_rx_stb == '0 && o_tx_stb == '0))
      else $error("output strobe high during reset");

endmodule

bind radio_frontend_top radio_frontend_assertions #(
   .NUM_RX_CHANNELS(NUM_RX_CHANNELS),
   .NUM_TX_CHANNELS(NUM_TX_CHANNELS)
) radio_frontend_assertions_inst (
   .radio_clk  (radio_clk),
   .i_reset    (i_reset),
   .i_rb_stb   (i_rb_stb),
   .i_rx_stb   (i_rx_stb),
   .o_rb_valid (o_rb_valid),
   .o_rx_stb   (o_rx_stb),
   .o_tx_stb   (o_tx_stb)
);

/* verification/radio_frontend_tb.sv */
// Testbench for one radio slot. Random settings, readback and sample traffic
// are checked against a model of the register map and of the front-end correction.
module radio_frontend_tb
   import radio_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ns;

   localparam int NUM_RX  = 2;
   localparam int NUM_TX  = 1;
   localparam int TIMEOUT = 20;                   // cycles allowed for any response

   logic                    radio_clk = 1'b0;
   logic                    i_reset;
   set_bus_t                i_set;
   logic                    i_rb_stb;
   logic [7:0]              i_rb_addr;
   logic                    i_run_rx;
   logic                    i_run_tx;
   logic                    i_rx_stb;
   sample_t                 i_rx_data;
   logic                    i_tx_stb;
   sample_t [NUM_TX-1:0]    i_tx_data;
   logic [31:0]             i_db_gpio_in;
   logic [31:0]             i_misc_in;
   logic                    o_rb_valid;
   logic [31:0]             o_rb_data;
   logic [NUM_RX-1:0]       o_rx_stb;
   sample_t [NUM_RX-1:0]    o_rx_data;
   logic [NUM_TX-1:0]       o_tx_stb;
   sample_t [NUM_TX-1:0]    o_tx_data;
   logic [31:0]             o_db_gpio_out;
   logic [31:0]             o_db_gpio_ddr;
   logic [2:0]              o_radio_led;
   logic [31:0]             o_misc_out;

   // model state
   atr_cfg_t                m_atr;
   fe_ctrl_t [NUM_RX-1:0]   m_rx_fe;
   fe_ctrl_t [NUM_TX-1:0]   m_tx_fe;
   logic [31:0]             m_misc;
   logic                    wr_pending;           // write driven, not yet sampled
   logic [7:0]              wr_addr;
   logic [31:0]             wr_data;
   logic [31:0]             rb_exp_q[$];
   logic [NUM_RX*32-1:0]    rx_exp_q[$];
   logic [NUM_TX*32-1:0]    tx_exp_q[$];

   always #50 radio_clk = ~radio_clk;

   radio_frontend_top #(
      .NUM_RX_CHANNELS(NUM_RX),
      .NUM_TX_CHANNELS(NUM_TX)
   ) radio_frontend_top_inst (
      .radio_clk     (radio_clk),
      .i_reset       (i_reset),
      .i_set         (i_set),
      .i_rb_stb      (i_rb_stb),
      .i_rb_addr     (i_rb_addr),
      .i_run_rx      (i_run_rx),
      .i_run_tx      (i_run_tx),
      .i_rx_stb      (i_rx_stb),
      .i_rx_data     (i_rx_data),
      .i_tx_stb      (i_tx_stb),
      .i_tx_data     (i_tx_data),
      .i_db_gpio_in  (i_db_gpio_in),
      .i_misc_in     (i_misc_in),
      .o_rb_valid    (o_rb_valid),
      .o_rb_data     (o_rb_data),
      .o_rx_stb      (o_rx_stb),
      .o_rx_data     (o_rx_data),
      .o_tx_stb      (o_tx_stb),
      .o_tx_data     (o_tx_data),
      .o_db_gpio_out (o_db_gpio_out),
      .o_db_gpio_ddr (o_db_gpio_ddr),
      .o_radio_led   (o_radio_led),
      .o_misc_out    (o_misc_out)
   );

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         fail_run($sformatf("error: %s = %h, expected %h", name, got, exp));
   endtask

   // --------------------------------------------------
   // model
   // --------------------------------------------------
   function automatic logic [15:0] negate_half(input logic [15:0] x);
      if (x == 16'h8000)
         return 16'h7fff;                         // clip full scale
      return 16'(~x + 16'd1);
   endfunction

   function automatic logic [31:0] correct_word(input logic [31:0] w, input fe_ctrl_t c);
      logic [15:0] hi;
      logic [15:0] lo;
      hi = c.swap_iq ? w[15:0] : w[31:16];
      lo = c.swap_iq ? w[31:16] : w[15:0];
      if (c.invert_i)
         hi = negate_half(hi);
      if (c.invert_q)
         lo = negate_half(lo);
      return {hi, lo};
   endfunction

   function automatic logic [31:0] rand_word();
      logic [15:0] hi;
      logic [15:0] lo;
      hi = ($urandom_range(0, 3) == 0) ? 16'h8000 : 16'($urandom);
      lo = ($urandom_range(0, 3) == 0) ? 16'h8000 : 16'($urandom);
      return {hi, lo};
   endfunction

   task automatic apply_write(input logic [7:0] a, input logic [31:0] d);
      case (a)
         SR_GPIO_IDLE: m_atr.idle = d;
         SR_GPIO_RX:   m_atr.rx   = d;
         SR_GPIO_TX:   m_atr.tx   = d;
         SR_GPIO_FDX:  m_atr.fdx  = d;
         SR_GPIO_DDR:  m_atr.ddr  = d;
         SR_MISC_OUT:  m_misc     = d;
         default:      ;
      endcase
      for (int n = 0; n < NUM_RX; n++)
         if (a == SR_RX_FE_BASE + SR_FE_CHAN_OFFSET * 8'(n))
            m_rx_fe[n] = fe_ctrl_t'(d[2:0]);
      for (int n = 0; n < NUM_TX; n++)
         if (a == SR_TX_FE_BASE + SR_FE_CHAN_OFFSET * 8'(n))
            m_tx_fe[n] = fe_ctrl_t'(d[2:0]);
   endtask

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   task automatic step();
      @(posedge radio_clk);
      if (wr_pending)
         apply_write(wr_addr, wr_data);           // landed on this edge
      wr_pending = 1'b0;
      i_set.stb <= 1'b0;
      i_rb_stb  <= 1'b0;
      i_rx_stb  <= 1'b0;
      i_tx_stb  <= 1'b0;
   endtask

   task automatic drive_write(input logic [7:0] a, input logic [31:0] d);
      i_set      <= {1'b1, a, d};
      wr_pending = 1'b1;
      wr_addr    = a;
      wr_data    = d;
   endtask

   task automatic drive_read(input logic [7:0] a, input logic [31:0] exp);
      i_rb_stb  <= 1'b1;
      i_rb_addr <= a;
      rb_exp_q.push_back(exp);
   endtask

   task automatic drive_rx(input logic [31:0] w);
      logic [NUM_RX*32-1:0] exp;
      for (int n = 0; n < NUM_RX; n++)
         exp[n*32 +: 32] = correct_word(w, m_rx_fe[n]);
      i_rx_stb  <= 1'b1;
      i_rx_data <= w;
      rx_exp_q.push_back(exp);
   endtask

   task automatic drive_tx();
      logic [NUM_TX*32-1:0] exp;
      logic [31:0]          w;
      for (int n = 0; n < NUM_TX; n++)
      begin
         w = rand_word();
         exp[n*32 +: 32] = correct_word(w, m_tx_fe[n]);
         i_tx_data[n] <= w;
      end
      i_tx_stb <= 1'b1;
      tx_exp_q.push_back(exp);
   endtask

   task automatic drain_responses();
      int waited;
      waited = 0;
      while (rb_exp_q.size() + rx_exp_q.size() + tx_exp_q.size() != 0)
      begin
         if (waited >= TIMEOUT)
            fail_run("timeout: DUT did not deliver all expected responses");
         step();
         waited++;
      end
   endtask

   task automatic check_gpio(input logic rx, input logic tx);
      logic [31:0] word;
      logic [2:0]  led;
      case ({tx, rx})
         2'b00:   word = m_atr.idle;
         2'b01:   word = m_atr.rx;
         2'b10:   word = m_atr.tx;
         default: word = m_atr.fdx;
      endcase
      case ({tx, rx})
         2'b00:   led = 3'b000;                   // all off
         2'b01:   led = 3'b101;                   // rx only
         2'b10:   led = 3'b010;                   // tx only
         default: led = 3'b011;                   // both running
      endcase
      check_value("o_db_gpio_out", o_db_gpio_out, word);
      check_value("o_db_gpio_ddr", o_db_gpio_ddr, m_atr.ddr);
      check_value("o_radio_led", 32'(o_radio_led), 32'(led));
      check_value("o_misc_out", o_misc_out, m_misc);
   endtask

   // pops one expected entry per DUT strobe
   always @(negedge radio_clk)
   begin : response_monitor
      logic [NUM_RX*32-1:0] rx_exp;
      logic [NUM_TX*32-1:0] tx_exp;
      if (i_reset !== 1'b1 && o_rb_valid)
      begin
         if (rb_exp_q.size() == 0)
            fail_run("readback valid seen with no request outstanding");
         else
            check_value("o_rb_data", o_rb_data, rb_exp_q.pop_front());
      end
      if (i_reset !== 1'b1 && o_rx_stb != '0)
      begin
         check_value("o_rx_stb", 32'(o_rx_stb), 32'({NUM_RX{1'b1}}));
         if (rx_exp_q.size() == 0)
            fail_run("rx sample strobe seen with no sample sent");
         else
         begin
            rx_exp = rx_exp_q.pop_front();
            for (int n = 0; n < NUM_RX; n++)
               check_value($sformatf("o_rx_data[%0d]", n), o_rx_data[n].raw, rx_exp[n*32 +: 32]);
         end
      end
      if (i_reset !== 1'b1 && o_tx_stb != '0)
      begin
         if (tx_exp_q.size() == 0)
            fail_run("tx sample strobe seen with no sample sent");
         else
         begin
            tx_exp = tx_exp_q.pop_front();
            for (int n = 0; n < NUM_TX; n++)
               check_value($sformatf("o_tx_data[%0d]", n), o_tx_data[n].raw, tx_exp[n*32 +: 32]);
         end
      end
   end

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial
   begin
      logic [31:0] g;
      logic [31:0] mi;
      logic [7:0]  a;
      void'($urandom(88));
      i_reset <= 1'b1;
      i_set <= '0;
      i_rb_stb <= 1'b0;
      i_rb_addr <= '0;
      i_run_rx <= 1'b0;
      i_run_tx <= 1'b0;
      i_rx_stb <= 1'b0;
      i_rx_data <= '0;
      i_tx_stb <= 1'b0;
      i_tx_data <= '0;
      i_db_gpio_in <= '0;
      i_misc_in <= '0;
      m_atr = '0;
      m_rx_fe = '0;
      m_tx_fe = '0;
      m_misc = '0;
      wr_pending = 1'b0;
      repeat (5) @(posedge radio_clk);
      i_reset <= 1'b0;

      // reset values
      @(negedge radio_clk);
      check_value("o_rb_valid", 32'(o_rb_valid), 32'h0);
      check_value("o_rx_stb", 32'(o_rx_stb), 32'h0);
      check_value("o_tx_stb", 32'(o_tx_stb), 32'h0);
      check_gpio(1'b0, 1'b0);
      step();
      drive_read(RB_MISC_OUT, 32'h0);
      drain_responses();

      // readback of misc out, inputs, unmapped and back-to-back
      repeat (8)
      begin
         step();
         drive_write(SR_MISC_OUT, $urandom);
         step();
         drive_read(RB_MISC_OUT, m_misc);
      end
      g = $urandom;
      mi = $urandom;
      step();
      i_db_gpio_in <= g;
      i_misc_in <= mi;
      step();
      step();
      a = 8'($urandom_range(19, 255));
      drive_read(RB_GPIO_IN, g);
      step();
      drive_read(RB_MISC_IN, mi);
      step();
      drive_read(a, 32'h0);
      step();
      drive_read(RB_MISC_OUT, m_misc);
      drain_responses();

      // ATR gpio through all run states
      for (int k = 0; k < 6; k++)
      begin
         step();
         drive_write(SR_DB_BASE + 8'(k), $urandom);
      end
      for (int s = 0; s < 4; s++)
      begin
         step();
         i_run_rx <= s[0];
         i_run_tx <= s[1];
         step();
         step();
         @(negedge radio_clk);
         check_gpio(s[0], s[1]);
      end

      // receive correction, control rewritten between bursts
      repeat (4)
      begin
         for (int n = 0; n < NUM_RX; n++)
         begin
            step();
            drive_write(SR_RX_FE_BASE + SR_FE_CHAN_OFFSET * 8'(n), $urandom_range(0, 7));
         end
         repeat (20)
         begin
            step();
            drive_rx(rand_word());
         end
      end
      drain_responses();

      // transmit correction, gaps and a control change mid-stream
      step();
      drive_write(SR_TX_FE_BASE, $urandom_range(0, 7));
      for (int k = 0; k < 80; k++)
      begin
         step();
         if (k == 40)
            drive_write(SR_TX_FE_BASE, 32'(~m_tx_fe[0]));
         if (k == 40 || k == 41 || $urandom_range(0, 2) != 0)
            drive_tx();
      end
      drain_responses();

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

/* src.f */
hdl/radio_pkg.sv
hdl/radio_settings_ctrl.sv
hdl/atr_gpio.sv
hdl/fe_iq_corrector.sv
hdl/radio_frontend_top.sv
verification/radio_frontend_assertions.sv
verification/radio_frontend_tb.sv

/* Makefile */
# Verilator build and run for the radio slot testbench.
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only -Wall --timing
TOP       := radio_frontend_tb
RTL_TOP   := radio_frontend_top
FILELIST  := src.f
RTL_FILES := $(shell grep '^hdl/' $(FILELIST))
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
